//--- stream_macros.svh
// ####################
// stream reader macros
// bus, FIFO and counter sizes
// ####################

`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// data and address bus width
`define STREAM_BUS_W 32

// address FIFO entries, power of two, at least 2
`define STREAM_FIFO_DEPTH 4

// element count and beat counter width
`define STREAM_CNT_W 16

// bytes per bus word
`define STREAM_BYTES (`STREAM_BUS_W/8)

`endif

//--- stream_pkg.sv
// ####################
// stream reader types
// job, flags, beat and address views
// ####################

`include "stream_macros.svh"

package stream_pkg;

  // one job as written by the host
  typedef struct packed {
    logic [`STREAM_BUS_W-1:0] base_addr; // first byte address
    logic [`STREAM_CNT_W-1:0] stride;    // byte step
    logic [`STREAM_CNT_W-1:0] tot_len;   // number of elements
  } stream_ctrl_t;

  // job status seen by the host
  typedef struct packed {
    logic ready_start; // idle, new job accepted
    logic busy;        // job in progress
    logic done;        // one cycle pulse
  } stream_flags_t;

  // output stream beat
  typedef struct packed {
    logic [`STREAM_BUS_W-1:0] data;
    logic                     last; // final beat of the job
  } stream_beat_t;

  // byte address, raw or split into word index and byte offset
  typedef union packed {
    logic [`STREAM_BUS_W-1:0] raw;
    struct packed {
      logic [`STREAM_BUS_W-3:0] word_idx;
      logic [1:0]               byte_off;
    } f;
  } stream_addr_u;

  // controller states
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    WORKING = 2'd1,
    DRAIN   = 2'd2
  } stream_state_e;

endpackage

//--- stream_addr_gen.sv
// ####################
// stream address generator
// steps from base by stride, one address per transfer
// ####################

`timescale 1ns/1ns

`include "stream_macros.svh"

module stream_addr_gen import stream_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  input  stream_ctrl_t ctrl_i,
  output logic         addr_valid_o,
  input  logic         addr_ready_i,
  output stream_addr_u addr_o,
  output logic         gen_done_o
);

  stream_addr_u             addr_q;
  logic [`STREAM_CNT_W-1:0] remain_q;   // addresses still to hand out
  logic                     done_q;
  logic                     xfer;
  logic [`STREAM_BUS_W-1:0] stride_ext;

  // stride is unsigned, widen to the bus
  assign stride_ext = {{(`STREAM_BUS_W-`STREAM_CNT_W){1'b0}}, ctrl_i.stride};

  assign addr_valid_o = (remain_q != '0);
  assign xfer         = addr_valid_o & addr_ready_i;
  assign addr_o       = addr_q;
  assign gen_done_o   = done_q;

  // current address
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q.raw <= ctrl_i.base_addr;
    end else if (xfer) begin
      addr_q.raw <= addr_q.raw + stride_ext; // next element
    end
  end

  // remaining count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remain_q <= '0;
    end else if (start_i) begin
      remain_q <= ctrl_i.tot_len;
    end else if (xfer) begin
      remain_q <= remain_q - 1'b1;
    end
  end

  // done holds until the next job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_i) begin
      done_q <= 1'b0;
    end else if (xfer && remain_q == 1) begin
      done_q <= 1'b1; // last address handed over
    end
  end

endmodule

//--- stream_fifo.sv
// ####################
// address FIFO
// circular buffer, valid/ready on both sides
// ####################

`timescale 1ns/1ns

`include "stream_macros.svh"

module stream_fifo import stream_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         push_valid_i,
  output logic         push_ready_o,
  input  stream_addr_u push_data_i,
  output logic         pop_valid_o,
  input  logic         pop_ready_i,
  output stream_addr_u pop_data_o,
  output logic         empty_o
);

  localparam int unsigned DEPTH = `STREAM_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  stream_addr_u     mem_q [DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] fill_q;
  logic             push;
  logic             pop;

  assign push_ready_o = (fill_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (fill_q != '0);
  assign empty_o      = (fill_q == '0);
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;
  assign pop_data_o   = mem_q[rptr_q]; // storage is the output register

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      fill_q <= '0;
    end else begin
      if (push) wptr_q <= wptr_q + 1'b1; // wraps at depth
      if (pop) rptr_q <= rptr_q + 1'b1;
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop && !push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

endmodule

//--- stream_source.sv
// ####################
// stream source engine
// job FSM, Wishbone classic reads, realign, beat output
// ####################

`timescale 1ns/1ns

`include "stream_macros.svh"

module stream_source import stream_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  stream_ctrl_t               ctrl_i,
  input  logic                       gen_done_i,
  input  logic                       fifo_valid_i,
  output logic                       fifo_ready_o,
  input  stream_addr_u               fifo_data_i,
  input  logic                       fifo_empty_i,
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output logic [`STREAM_BUS_W-1:0]   wb_adr_o,
  output logic [`STREAM_BYTES-1:0]   wb_sel_o,
  input  logic [`STREAM_BUS_W-1:0]   wb_dat_i,
  input  logic                       wb_ack_i,
  output stream_beat_t               beat_o,
  output logic                       beat_valid_o,
  input  logic                       beat_ready_i,
  output stream_flags_t              flags_o
);

  stream_state_e            cs, ns;
  logic                     req_q;      // cyc and stb
  logic [`STREAM_BUS_W-1:0] adr_q;
  logic [1:0]               off_q;      // byte offset of the access
  stream_beat_t             beat_q;
  logic                     beat_valid_q;
  logic [`STREAM_CNT_W-1:0] beat_cnt_q; // beats accepted downstream
  logic                     cnt_clr;
  logic                     issue;
  logic                     ack;
  logic                     beat_xfer;
  logic [`STREAM_BUS_W-1:0] rdata_aligned;

  // one access at a time, never while a beat is held
  assign issue     = !req_q & fifo_valid_i & !beat_valid_q;
  assign ack       = req_q & wb_ack_i;
  assign beat_xfer = beat_valid_q & beat_ready_i;

  assign wb_cyc_o     = req_q;
  assign wb_stb_o     = req_q;
  assign wb_we_o      = 1'b0;        // read only
  assign wb_adr_o     = adr_q;
  assign wb_sel_o     = '1;
  assign fifo_ready_o = ack;         // pop in the ack cycle
  assign beat_o       = beat_q;
  assign beat_valid_o = beat_valid_q;

  // drop the leading bytes, zero fill on top
  assign rdata_aligned = wb_dat_i >> {off_q, 3'b000};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else if (issue) begin
      req_q <= 1'b1;
    end else if (ack) begin
      req_q <= 1'b0;
    end
  end

  // word aligned address and offset of the head entry
  always_ff @(posedge clk_i) begin
    if (issue) begin
      adr_q <= {fifo_data_i.f.word_idx, 2'b00};
      off_q <= fifo_data_i.f.byte_off;
    end
  end

  // output register payload
  always_ff @(posedge clk_i) begin
    if (ack) begin
      beat_q.data <= rdata_aligned;
      beat_q.last <= (beat_cnt_q + 1'b1 == ctrl_i.tot_len); // earlier beats all gone
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_valid_q <= 1'b0;
    end else if (ack) begin
      beat_valid_q <= 1'b1;
    end else if (beat_xfer) begin
      beat_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (cnt_clr) begin
      beat_cnt_q <= '0;
    end else if (beat_xfer) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= IDLE;
    end else begin
      cs <= ns;
    end
  end

  // job control
  always_comb begin
    ns                  = cs;
    cnt_clr             = 1'b0;
    flags_o.ready_start = 1'b0;
    flags_o.busy        = 1'b1;
    flags_o.done        = 1'b0;
    case (cs)
      IDLE: begin
        flags_o.ready_start = 1'b1;
        flags_o.busy        = 1'b0;
        if (start_i) ns = WORKING;
      end
      WORKING: begin
        if (gen_done_i) ns = DRAIN; // all addresses in the FIFO
      end
      DRAIN: begin
        if (fifo_empty_i && beat_cnt_q == ctrl_i.tot_len) begin
          ns           = IDLE;
          flags_o.done = 1'b1;
          cnt_clr      = 1'b1;
        end
      end
      default: ns = IDLE;
    endcase
  end

endmodule

//--- stream_reader_top.sv
// ####################
// memory read streamer
// address generator, FIFO and source engine
// ####################

`timescale 1ns/1ns

`include "stream_macros.svh"

module stream_reader_top import stream_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  stream_ctrl_t             ctrl_i,
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [`STREAM_BUS_W-1:0] wb_adr_o,
  output logic [`STREAM_BYTES-1:0] wb_sel_o,
  input  logic [`STREAM_BUS_W-1:0] wb_dat_i,
  input  logic                     wb_ack_i,
  output stream_beat_t             beat_o,
  output logic                     beat_valid_o,
  input  logic                     beat_ready_i,
  output stream_flags_t            flags_o
);

  logic         start_taken; // start seen only in idle
  logic         gen_done;
  logic         addr_valid;
  logic         addr_ready;
  stream_addr_u addr_data;
  logic         fifo_valid;
  logic         fifo_ready;
  stream_addr_u fifo_data;
  logic         fifo_empty;

  assign start_taken = start_i & flags_o.ready_start;

  stream_addr_gen stream_addr_gen_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_taken),
    .ctrl_i       (ctrl_i),
    .addr_valid_o (addr_valid),
    .addr_ready_i (addr_ready),
    .addr_o       (addr_data),
    .gen_done_o   (gen_done)
  );

  stream_fifo stream_fifo_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (addr_valid),
    .push_ready_o (addr_ready),
    .push_data_i  (addr_data),
    .pop_valid_o  (fifo_valid),
    .pop_ready_i  (fifo_ready),
    .pop_data_o   (fifo_data),
    .empty_o      (fifo_empty)
  );

  stream_source stream_source_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .ctrl_i       (ctrl_i),
    .gen_done_i   (gen_done),
    .fifo_valid_i (fifo_valid),
    .fifo_ready_o (fifo_ready),
    .fifo_data_i  (fifo_data),
    .fifo_empty_i (fifo_empty),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_sel_o     (wb_sel_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .beat_o       (beat_o),
    .beat_valid_o (beat_valid_o),
    .beat_ready_i (beat_ready_i),
    .flags_o      (flags_o)
  );

endmodule

//--- tb_clk_gen.sv
// ####################
// testbench clock and reset
// ####################

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD/2) clk_o = ~clk_o;
  end

  // low for three rising edges
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #5 rst_no = 1'b1;
  end

endmodule

//--- tb_checker.sv
// ####################
// stream reader monitor
// predicts beats and done, counts mismatches
// ####################

`timescale 1ns/1ns

`include "stream_macros.svh"

module tb_checker import stream_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  stream_ctrl_t             row_i,
  input  logic                     row_load_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [`STREAM_BUS_W-1:0] wb_adr_i,
  input  logic [`STREAM_BYTES-1:0] wb_sel_i,
  input  stream_beat_t             beat_i,
  input  logic                     beat_valid_i,
  input  logic                     beat_ready_i,
  input  stream_flags_t            flags_i,
  output int                       err_cnt_o,
  output int                       jobs_o
);

  stream_ctrl_t             row_q;
  logic [`STREAM_BUS_W-1:0] beat_idx;
  logic [`STREAM_BUS_W-1:0] exp_addr;
  logic [`STREAM_BUS_W-1:0] exp_data;
  logic                     exp_last;
  logic                     in_job;
  logic                     reset_seen;

  // memory byte a holds a[7:0] ^ 5A
  // output byte k comes from addr + k
  function automatic logic [`STREAM_BUS_W-1:0] expected_data(input logic [`STREAM_BUS_W-1:0] addr);
    logic [`STREAM_BUS_W-1:0] res;
    logic [`STREAM_BUS_W-1:0] byte_addr;
    res = '0;
    for (int k = 0; k < 4; k++) begin
      byte_addr = addr + k;
      if (k < 4 - addr[1:0]) res[8*k +: 8] = byte_addr[7:0] ^ 8'h5A; // zero fill above
    end
    return res;
  endfunction

  initial begin
    err_cnt_o  = 0;
    jobs_o     = 0;
    in_job     = 1'b0;
    reset_seen = 1'b0;
    beat_idx   = '0;
    row_q      = '0;
  end

  // sampled mid cycle
  always @(negedge clk_i) begin
    if (rst_ni && !reset_seen) begin
      reset_seen = 1'b1;
      if (!flags_i.ready_start || flags_i.busy || flags_i.done || beat_valid_i ||
          wb_cyc_i || wb_stb_i) begin
        err_cnt_o++;
        $display("Fail %0t: status after reset is %b, beat_valid %b, cyc %b, stb %b", $time,
                 flags_i, beat_valid_i, wb_cyc_i, wb_stb_i);
      end
    end
    if (rst_ni) begin
      if (wb_cyc_i !== wb_stb_i) begin
        err_cnt_o++;
        $display("Fail %0t: Wishbone cyc %b and stb %b differ", $time, wb_cyc_i, wb_stb_i);
      end else if (wb_cyc_i && (wb_we_i || wb_sel_i != '1 || wb_adr_i[1:0] != 2'b00)) begin
        err_cnt_o++;
        $display("Fail %0t: request adr %h we %b sel %b, expected an aligned word read",
                 $time, wb_adr_i, wb_we_i, wb_sel_i);
      end

      if (row_load_i) begin
        if (in_job) begin
          err_cnt_o++;
          $display("A new job was started at %0t before the previous one finished", $time);
        end
        row_q    = row_i;
        beat_idx = '0;
        in_job   = 1'b1;
      end else if (in_job && (flags_i.ready_start || !flags_i.busy)) begin
        err_cnt_o++;
        $display("Fail %0t: flags %b during a job, expected not ready and busy", $time, flags_i);
      end

      if (beat_valid_i && beat_ready_i) begin
        if (!in_job || beat_idx >= row_q.tot_len) begin
          err_cnt_o++;
          $display("An extra beat with data %h left the streamer at %0t", beat_i.data, $time);
        end else begin
          exp_addr = row_q.base_addr + beat_idx * row_q.stride;
          exp_data = expected_data(exp_addr);
          exp_last = (beat_idx + 1 == row_q.tot_len);
          if (beat_i.data !== exp_data || beat_i.last !== exp_last) begin
            err_cnt_o++;
            $display("Fail %0t: beat %0d addr %h got %h/%b expected %h/%b", $time, beat_idx,
                     exp_addr, beat_i.data, beat_i.last, exp_data, exp_last);
          end
        end
        beat_idx = beat_idx + 1;
      end

      if (flags_i.done) begin
        if (!in_job) begin
          err_cnt_o++;
          $display("Done pulsed at %0t with no job running", $time);
        end else if (beat_idx != row_q.tot_len) begin
          err_cnt_o++;
          $display("Done pulsed at %0t after %0d of %0d beats, final beat missing", $time,
                   beat_idx, row_q.tot_len);
        end
        in_job = 1'b0;
        jobs_o++;
      end
    end
  end

endmodule

//--- tb_stream_reader.sv
// ####################
// stream reader testbench
// job table, Wishbone memory model, watchdog
// ####################

`timescale 1ns/1ns

`include "stream_macros.svh"

module tb_stream_reader import stream_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int NUM_JOBS   = 10;

  typedef struct packed {
    stream_ctrl_t ctrl;
    logic         bp;   // random beat_ready
  } job_row_t;

  job_row_t                 job_tbl [NUM_JOBS];
  logic                     clk;
  logic                     rst_n;
  logic                     start;
  stream_ctrl_t             ctrl;
  logic                     row_load;
  logic                     bp_mode;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`STREAM_BUS_W-1:0] wb_adr;
  logic [`STREAM_BYTES-1:0] wb_sel;
  logic [`STREAM_BUS_W-1:0] wb_dat;
  logic                     wb_ack;
  stream_beat_t             beat;
  logic                     beat_valid;
  logic                     beat_ready;
  stream_flags_t            flags;
  logic                     armed;
  int                       wait_cnt;
  int                       chk_errs;
  int                       jobs_seen;
  int                       tb_errs;

  tb_clk_gen #(.PERIOD(CLK_PERIOD)) tb_clk_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  stream_reader_top stream_reader_top_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .start_i      (start),
    .ctrl_i       (ctrl),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_we_o      (wb_we),
    .wb_adr_o     (wb_adr),
    .wb_sel_o     (wb_sel),
    .wb_dat_i     (wb_dat),
    .wb_ack_i     (wb_ack),
    .beat_o       (beat),
    .beat_valid_o (beat_valid),
    .beat_ready_i (beat_ready),
    .flags_o      (flags)
  );

  tb_checker tb_checker_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .row_i        (ctrl),
    .row_load_i   (row_load),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_sel_i     (wb_sel),
    .beat_i       (beat),
    .beat_valid_i (beat_valid),
    .beat_ready_i (beat_ready),
    .flags_i      (flags),
    .err_cnt_o    (chk_errs),
    .jobs_o       (jobs_seen)
  );

  task automatic add_job(input int idx, input logic [31:0] base, input logic [15:0] stride,
                         input logic [15:0] len, input logic bp);
    job_tbl[idx] = {base, stride, len, bp};
  endtask

  // little endian word of bytes a[7:0] ^ 5A
  function automatic logic [`STREAM_BUS_W-1:0] mem_word(input logic [`STREAM_BUS_W-1:0] adr);
    logic [`STREAM_BUS_W-1:0] a;
    a = {adr[`STREAM_BUS_W-1:2], 2'b00};
    return {(a[7:0] + 8'd3) ^ 8'h5A, (a[7:0] + 8'd2) ^ 8'h5A,
            (a[7:0] + 8'd1) ^ 8'h5A, a[7:0] ^ 8'h5A};
  endfunction

  // Wishbone classic slave with 0 to 3 wait cycles
  always begin
    @(posedge clk);
    #5;
    if (wb_ack) begin
      wb_ack = 1'b0; // taken at this edge
      armed  = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!armed) begin
        armed    = 1'b1;
        wait_cnt = $urandom % 4;
      end
      if (wait_cnt == 0) begin
        wb_dat = mem_word(wb_adr);
        wb_ack = 1'b1;
      end else begin
        wait_cnt--;
      end
    end
  end

  // output back-pressure
  always begin
    @(posedge clk);
    #5;
    beat_ready = bp_mode ? ($urandom % 4 != 0) : 1'b1;
  end

  initial begin
    void'($urandom(32'h4959));
    start      = 1'b0;
    ctrl       = '0;
    row_load   = 1'b0;
    bp_mode    = 1'b0;
    wb_dat     = '0;
    wb_ack     = 1'b0;
    beat_ready = 1'b1;
    armed      = 1'b0;
    wait_cnt   = 0;
    tb_errs    = 0;
    add_job(0, 32'h0000_0100, 16'd4, 16'd8, 1'b0);  // aligned unit stride
    add_job(1, 32'h0000_0201, 16'd4, 16'd5, 1'b0);
    add_job(2, 32'h0000_0302, 16'd4, 16'd5, 1'b0);
    add_job(3, 32'h0000_0403, 16'd4, 16'd5, 1'b0);
    add_job(4, 32'h0000_0500, 16'd12, 16'd6, 1'b0);
    add_job(5, 32'h0000_0611, 16'd5, 16'd9, 1'b0);  // odd stride walks the offsets
    add_job(6, 32'h0000_0700, 16'd4, 16'd12, 1'b1);
    add_job(7, 32'h0000_0803, 16'd5, 16'd10, 1'b1);
    add_job(8, 32'h0000_0900, 16'd4, 16'd1, 1'b0);  // single element
    add_job(9, 32'h0000_09F7, 16'd7, 16'd1, 1'b1);
    @(posedge rst_n);
    for (int j = 0; j < NUM_JOBS; j++) begin
      @(posedge clk);
      #5;
      while (!flags.ready_start) begin
        @(posedge clk);
        #5;
      end
      ctrl     = job_tbl[j].ctrl;
      bp_mode  = job_tbl[j].bp;
      start    = 1'b1;
      row_load = 1'b1;
      @(posedge clk);
      #5;
      start    = 1'b0;
      row_load = 1'b0;
      while (!flags.done) begin
        @(posedge clk);
        #5;
      end
    end
    bp_mode = 1'b0;
    repeat (4) @(posedge clk); // catch stray beats
    if (jobs_seen != NUM_JOBS) begin
      tb_errs++;
      $display("Only %0d of %0d jobs reported done", jobs_seen, NUM_JOBS);
    end
    $display("errors: checker %0d, testbench %0d, jobs %0d", chk_errs, tb_errs, jobs_seen);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // ten cycles per element plus slack
  initial begin
    int total;
    total = 0;
    @(posedge rst_n);
    for (int j = 0; j < NUM_JOBS; j++) total += job_tbl[j].ctrl.tot_len;
    #((total * 10 + 200) * CLK_PERIOD);
    $display("Watchdog expired at %0t, the jobs did not finish in time", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
stream_pkg.sv
stream_addr_gen.sv
stream_fifo.sv
stream_source.sv
stream_reader_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_stream_reader.sv

//--- Bender.yml
package:
  name: stream_reader

sources:
  - include_dirs:
      - .
    files:
      - stream_pkg.sv
      - stream_addr_gen.sv
      - stream_fifo.sv
      - stream_source.sv
      - stream_reader_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_stream_reader.sv
